/* rtl/bp_pkg.sv */
package bp_pkg;

    // fetch geometry
    localparam int FETCH_WIDTH = 2;

    // table sizes
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_TAG_BITS   = 26;
    localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
    localparam int BHT_INDEX_BITS = 4;
    localparam int BHT_ENTRIES    = 1 << BHT_INDEX_BITS;
    localparam int HIST_BITS      = 4;
    localparam int PHT_ENTRIES    = 1 << HIST_BITS;

    typedef logic [31:0] addr_t;

    // instructions are one word apart
    localparam addr_t INSN_BYTES = 32'd4;

    typedef struct packed {
        logic                    valid;
        logic [BTB_TAG_BITS-1:0] tag;
        addr_t                   target;
    } btb_entry_t;

    // one-bit direction state per pattern
    typedef enum logic {
        PHT_NOT_TAKEN = 1'b0,
        PHT_TAKEN     = 1'b1
    } pht_state_t;

    // APB register map
    typedef logic [3:0] csr_addr_t;
    localparam csr_addr_t CSR_MODE        = 4'h0;
    localparam csr_addr_t CSR_TAKEN_COUNT = 4'h4;
    localparam logic      MODE_RESET      = 1'b1;

    // word offset bits 1:0 are skipped by every table index
    function automatic logic [BTB_INDEX_BITS-1:0] btb_index(addr_t pc);
        return pc[BTB_INDEX_BITS+1:2];
    endfunction

    function automatic logic [BTB_TAG_BITS-1:0] btb_tag(addr_t pc);
        return pc[31:BTB_INDEX_BITS+2];
    endfunction

    function automatic logic [BHT_INDEX_BITS-1:0] bht_index(addr_t pc);
        return pc[BHT_INDEX_BITS+1:2];
    endfunction

endpackage

/* rtl/resolve_if.sv */
interface resolve_if;
    import bp_pkg::*;

    // one element per resolve lane, lane 0 is oldest
    logic  [FETCH_WIDTH-1:0] valid;
    addr_t [FETCH_WIDTH-1:0] pc;
    logic  [FETCH_WIDTH-1:0] taken;
    addr_t [FETCH_WIDTH-1:0] target;

    // driven from the ROB side
    modport source (
        output valid,
        output pc,
        output taken,
        output target
    );

    // table training and counting
    modport sink (
        input valid,
        input pc,
        input taken,
        input target
    );

endinterface

/* rtl/branch_target_buffer.sv */
module branch_target_buffer (
    input  logic                                     clock,
    input  logic                                     reset,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  lookup_pc,
    resolve_if.sink                                  resolve,
    output logic [bp_pkg::FETCH_WIDTH-1:0]           hit,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  target
);
    import bp_pkg::*;

    btb_entry_t entries [BTB_ENTRIES];

    // lookup index and tag per lane
    logic [FETCH_WIDTH-1:0][BTB_INDEX_BITS-1:0] lookup_index;
    logic [FETCH_WIDTH-1:0][BTB_TAG_BITS-1:0]   lookup_tag;

    // write side, one port per resolve lane
    logic [FETCH_WIDTH-1:0]                     write_en;
    logic [FETCH_WIDTH-1:0][BTB_INDEX_BITS-1:0] write_index;
    btb_entry_t [FETCH_WIDTH-1:0]               write_entry;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lane
        btb_entry_t read_entry;

        assign lookup_index[i] = btb_index(lookup_pc[i]);
        assign lookup_tag[i]   = btb_tag(lookup_pc[i]);
        assign read_entry      = entries[lookup_index[i]];

        // hit needs a live entry with the same upper pc bits
        assign hit[i]    = read_entry.valid && (read_entry.tag == lookup_tag[i]);
        assign target[i] = read_entry.target;

        // only taken branches allocate
        assign write_en[i]           = resolve.valid[i] && resolve.taken[i];
        assign write_index[i]        = btb_index(resolve.pc[i]);
        assign write_entry[i].valid  = 1'b1;
        assign write_entry[i].tag    = btb_tag(resolve.pc[i]);
        assign write_entry[i].target = resolve.target[i];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int e = 0; e < BTB_ENTRIES; e++) begin
                entries[e].valid <= 1'b0;
            end
        end else begin
            // ascending order, so the higher lane wins a shared index
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (write_en[i]) begin
                    entries[write_index[i]] <= write_entry[i];
                end
            end
        end
    end

endmodule

/* rtl/local_history_predictor.sv */
module local_history_predictor (
    input  logic                                     clock,
    input  logic                                     reset,
    input  bp_pkg::addr_t                            pc_start,
    input  logic                                     dynamic_enable,
    resolve_if.sink                                  resolve,
    output logic [bp_pkg::FETCH_WIDTH-1:0]           pred_valid,
    output logic [bp_pkg::FETCH_WIDTH-1:0]           pred_taken,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  pred_pc
);
    import bp_pkg::*;

    typedef logic [HIST_BITS-1:0] hist_t;

    // per-branch local history and history-indexed direction
    hist_t      [BHT_ENTRIES-1:0] bht;
    hist_t      [BHT_ENTRIES-1:0] bht_next;
    pht_state_t [PHT_ENTRIES-1:0] pht;
    pht_state_t [PHT_ENTRIES-1:0] pht_next;

    addr_t [FETCH_WIDTH-1:0] lane_pc;
    addr_t [FETCH_WIDTH-1:0] fall_through;
    logic  [FETCH_WIDTH-1:0] btb_hit;
    addr_t [FETCH_WIDTH-1:0] btb_target;
    logic  [FETCH_WIDTH-1:0] dyn_taken;

    logic [FETCH_WIDTH-1:0][BHT_INDEX_BITS-1:0] resolve_index;

    for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_lane
        hist_t lane_hist;

        assign lane_pc[i]      = pc_start + addr_t'(i) * INSN_BYTES;
        assign fall_through[i] = lane_pc[i] + INSN_BYTES;
        assign lane_hist       = bht[bht_index(lane_pc[i])];

        // direction from the pht, target must come from the btb
        assign dyn_taken[i] = (pht[lane_hist] == PHT_TAKEN) && btb_hit[i];

        assign resolve_index[i] = bht_index(resolve.pc[i]);
    end

    branch_target_buffer i_btb (
        .clock     (clock),
        .reset     (reset),
        .lookup_pc (lane_pc),
        .resolve   (resolve),
        .hit       (btb_hit),
        .target    (btb_target)
    );

    // lane outputs
    always_comb begin
        logic seen_taken;

        seen_taken = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (dynamic_enable) begin
                // lanes past a taken branch are on the wrong path
                pred_valid[i] = !seen_taken;
                pred_taken[i] = dyn_taken[i];
                pred_pc[i]    = dyn_taken[i] ? btb_target[i] : fall_through[i];
                seen_taken    = seen_taken | dyn_taken[i];
            end else begin
                // static fallback, always not taken
                pred_valid[i] = 1'b1;
                pred_taken[i] = 1'b0;
                pred_pc[i]    = fall_through[i];
            end
        end
    end

    // training runs in both modes
    always_comb begin
        bht_next = bht;
        pht_next = pht;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (resolve.valid[i]) begin
                // pht uses the history from before this cycle
                pht_next[bht[resolve_index[i]]] =
                    resolve.taken[i] ? PHT_TAKEN : PHT_NOT_TAKEN;
                // history chains across lanes that share an entry
                bht_next[resolve_index[i]] =
                    {bht_next[resolve_index[i]][HIST_BITS-2:0], resolve.taken[i]};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            bht <= '0;
            for (int e = 0; e < PHT_ENTRIES; e++) begin
                pht[e] <= PHT_NOT_TAKEN;
            end
        end else begin
            bht <= bht_next;
            pht <= pht_next;
        end
    end

endmodule

/* rtl/predictor_csr.sv */
module predictor_csr (
    input  logic              clock,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  bp_pkg::csr_addr_t paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    resolve_if.sink           resolve,
    output logic              dynamic_enable
);
    import bp_pkg::*;

    logic [31:0] taken_count;
    logic [31:0] taken_lanes;

    logic        access;
    logic        addr_mapped;
    logic        addr_read_only;
    logic [31:0] read_value;
    logic        mode_write;

    // no wait states, every access phase completes
    assign access = psel && penable;
    assign pready = access;

    // address decode
    always_comb begin
        addr_mapped    = 1'b1;
        addr_read_only = 1'b0;
        read_value     = '0;
        case (paddr)
            CSR_MODE: begin
                read_value = {31'b0, dynamic_enable};
            end
            CSR_TAKEN_COUNT: begin
                read_value     = taken_count;
                addr_read_only = 1'b1;
            end
            default: begin
                addr_mapped = 1'b0;
            end
        endcase
    end

    assign pslverr    = access && (!addr_mapped || (pwrite && addr_read_only));
    assign prdata     = (access && !pwrite) ? read_value : '0;
    assign mode_write = access && pwrite && (paddr == CSR_MODE);

    // population count of taken resolves this cycle
    always_comb begin
        taken_lanes = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            taken_lanes = taken_lanes + 32'(resolve.valid[i] & resolve.taken[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dynamic_enable <= MODE_RESET;
        end else if (mode_write) begin
            dynamic_enable <= pwdata[0];
        end
    end

    // wraps at 2^32
    always_ff @(posedge clock) begin
        if (reset) begin
            taken_count <= '0;
        end else begin
            taken_count <= taken_count + taken_lanes;
        end
    end

endmodule

/* rtl/fetch_predictor.sv */
module fetch_predictor (
    input  logic                                     clock,
    input  logic                                     reset,

    // fetch
    input  bp_pkg::addr_t                            pc_start,

    // resolve lanes from the ROB
    input  logic [bp_pkg::FETCH_WIDTH-1:0]           resolve_valid,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  resolve_pc,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]           resolve_taken,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  resolve_target,

    // predictions
    output logic [bp_pkg::FETCH_WIDTH-1:0]           pred_valid,
    output logic [bp_pkg::FETCH_WIDTH-1:0]           pred_taken,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]  pred_pc,

    // APB
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  bp_pkg::csr_addr_t                        paddr,
    input  logic [31:0]                              pwdata,
    output logic [31:0]                              prdata,
    output logic                                     pready,
    output logic                                     pslverr
);
    logic dynamic_enable;

    resolve_if resolve_bus ();

    // drive the bus from the plain ports, the source side
    assign resolve_bus.valid  = resolve_valid;
    assign resolve_bus.pc     = resolve_pc;
    assign resolve_bus.taken  = resolve_taken;
    assign resolve_bus.target = resolve_target;

    local_history_predictor i_predictor (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .dynamic_enable (dynamic_enable),
        .resolve        (resolve_bus.sink),
        .pred_valid     (pred_valid),
        .pred_taken     (pred_taken),
        .pred_pc        (pred_pc)
    );

    predictor_csr i_csr (
        .clock          (clock),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .resolve        (resolve_bus.sink),
        .dynamic_enable (dynamic_enable)
    );

endmodule

/* test/fetch_predictor_chk.sv */
module fetch_predictor_chk (
    input logic                            clock,
    input logic                            reset,
    input logic                            psel,
    input logic                            penable,
    input logic                            pwrite,
    input bp_pkg::csr_addr_t               paddr,
    input logic [31:0]                     pwdata,
    input logic                            pslverr,
    input logic                            dynamic_enable,
    input logic [bp_pkg::FETCH_WIDTH-1:0]  pred_valid
);
    import bp_pkg::*;

    // an accepted mode write shows up one cycle later
    a_mode_write_applies: assert property (
        @(posedge clock) disable iff (reset)
        (psel && penable && pwrite && !pslverr && paddr == CSR_MODE)
            |=> (dynamic_enable == $past(pwdata[0]))
    ) else $error("mode write did not reach dynamic_enable");

    // rejected accesses leave the mode bit alone
    a_slverr_keeps_mode: assert property (
        @(posedge clock) disable iff (reset)
        (psel && penable && pslverr) |=> $stable(dynamic_enable)
    ) else $error("mode bit changed after an APB error response");

    a_valid_known: assert property (
        @(posedge clock) disable iff (reset) !$isunknown(pred_valid)
    ) else $error("pred_valid has unknown bits");

endmodule

/* test/fetch_predictor_tb.sv */
module fetch_predictor_tb;
    import bp_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h886f_7f06;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // cycles per test, used for the timeout
    localparam int RESET_LEN   = 2;
    localparam int START_LEN   = 6;
    localparam int TRAIN_LEN   = HIST_BITS + 2;
    localparam int RANDOM_LEN  = 400;
    localparam int STATIC_LEN  = 46;
    localparam int COUNT_LEN   = 2;
    localparam int ERRORS_LEN  = 10;
    localparam int TIMEOUT_CYCLES = RESET_LEN + START_LEN + TRAIN_LEN + RANDOM_LEN
                                  + STATIC_LEN + COUNT_LEN + ERRORS_LEN + 100;

    logic                    clock;
    logic                    reset;
    addr_t                   pc_start;
    logic  [FETCH_WIDTH-1:0] resolve_valid;
    addr_t [FETCH_WIDTH-1:0] resolve_pc;
    logic  [FETCH_WIDTH-1:0] resolve_taken;
    addr_t [FETCH_WIDTH-1:0] resolve_target;
    logic  [FETCH_WIDTH-1:0] pred_valid;
    logic  [FETCH_WIDTH-1:0] pred_taken;
    addr_t [FETCH_WIDTH-1:0] pred_pc;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    csr_addr_t               paddr;
    logic [31:0]             pwdata;
    logic [31:0]             prdata;
    logic                    pready;
    logic                    pslverr;

    logic [31:0] lfsr_state;
    int          cycle_count;

    // reference model state
    btb_entry_t           model_btb [BTB_ENTRIES];
    logic [HIST_BITS-1:0] model_bht [BHT_ENTRIES];
    pht_state_t           model_pht [PHT_ENTRIES];
    logic                 model_mode;
    logic [31:0]          model_count;

    fetch_predictor i_dut (.*);

    bind local_history_predictor fetch_predictor_chk i_pred_chk (
        .clock(clock), .reset(reset), .psel(1'b0), .penable(1'b0),
        .pwrite(1'b0), .paddr('0), .pwdata('0), .pslverr(1'b0),
        .dynamic_enable(dynamic_enable), .pred_valid(pred_valid)
    );

    bind predictor_csr fetch_predictor_chk i_csr_chk (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable),
        .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .pslverr(pslverr),
        .dynamic_enable(dynamic_enable), .pred_valid('1)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Some tests failed");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? LFSR_TAPS : 32'h0);
        return out;
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < count; b++) begin
            value = {value[30:0], lfsr_bit()};
        end
        return value;
    endfunction

    // pairs share a table index with different tags
    function automatic addr_t pool_pc(logic [2:0] sel);
        case (sel)
            3'd0: return 32'h0000_1000;
            3'd1: return 32'h0000_1040;
            3'd2: return 32'h0000_1004;
            3'd3: return 32'h0000_2004;
            3'd4: return 32'h0000_1008;
            3'd5: return 32'h0000_100c;
            3'd6: return 32'h0000_300c;
            default: return 32'h0000_1010;
        endcase
    endfunction

    task automatic stop_on_error(string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pred(string name,
                              logic [FETCH_WIDTH-1:0] exp_valid,
                              logic [FETCH_WIDTH-1:0] exp_taken,
                              addr_t [FETCH_WIDTH-1:0] exp_pc,
                              logic [FETCH_WIDTH-1:0] act_valid,
                              logic [FETCH_WIDTH-1:0] act_taken,
                              addr_t [FETCH_WIDTH-1:0] act_pc);
        if (act_valid !== exp_valid || act_taken !== exp_taken || act_pc !== exp_pc) begin
            stop_on_error($sformatf(
                "ERROR %s expected valid=%b taken=%b pc=%h actual valid=%b taken=%b pc=%h",
                name, exp_valid, exp_taken, exp_pc, act_valid, act_taken, act_pc));
        end
    endtask

    task automatic check_csr_data(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("ERROR %s expected prdata=%h actual prdata=%h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_slverr(string name, logic expected, logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("ERROR %s expected pslverr=%b actual pslverr=%b",
                                    name, expected, actual));
        end
    endtask

    task automatic model_reset();
        for (int e = 0; e < BTB_ENTRIES; e++) begin
            model_btb[e] = '0;
        end
        for (int e = 0; e < BHT_ENTRIES; e++) begin
            model_bht[e] = '0;
        end
        for (int e = 0; e < PHT_ENTRIES; e++) begin
            model_pht[e] = PHT_NOT_TAKEN;
        end
        model_mode  = 1'b1;
        model_count = '0;
    endtask

    task automatic model_predict(output logic [FETCH_WIDTH-1:0] exp_valid,
                                 output logic [FETCH_WIDTH-1:0] exp_taken,
                                 output addr_t [FETCH_WIDTH-1:0] exp_pc);
        addr_t      lane;
        btb_entry_t entry;
        logic       dyn;
        logic       blocked;

        blocked = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane  = pc_start + 32'(4 * i);
            entry = model_btb[lane[5:2]];
            dyn   = model_mode && entry.valid && (entry.tag == lane[31:6])
                    && (model_pht[model_bht[lane[5:2]]] == PHT_TAKEN);
            exp_valid[i] = !blocked;
            exp_taken[i] = dyn;
            exp_pc[i]    = dyn ? entry.target : lane + 32'd4;
            blocked      = blocked | dyn;
        end
    endtask

    // applies what the coming clock edge does to the DUT state
    task automatic model_update();
        logic [HIST_BITS-1:0] old_bht [BHT_ENTRIES];
        logic [3:0]           idx;

        old_bht = model_bht;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (resolve_valid[i]) begin
                idx = resolve_pc[i][5:2];
                model_pht[old_bht[idx]] = resolve_taken[i] ? PHT_TAKEN : PHT_NOT_TAKEN;
                model_bht[idx] = {model_bht[idx][HIST_BITS-2:0], resolve_taken[i]};
                if (resolve_taken[i]) begin
                    model_btb[idx].valid  = 1'b1;
                    model_btb[idx].tag    = resolve_pc[i][31:6];
                    model_btb[idx].target = resolve_target[i];
                    model_count = model_count + 32'd1;
                end
            end
        end
        if (psel && penable && pwrite && paddr == CSR_MODE) begin
            model_mode = pwdata[0];
        end
    endtask

    // called mid cycle, returns at the next drive point
    task automatic end_cycle(string name);
        logic  [FETCH_WIDTH-1:0] exp_valid;
        logic  [FETCH_WIDTH-1:0] exp_taken;
        addr_t [FETCH_WIDTH-1:0] exp_pc;

        model_predict(exp_valid, exp_taken, exp_pc);
        check_pred(name, exp_valid, exp_taken, exp_pc, pred_valid, pred_taken, pred_pc);
        model_update();
        @(posedge clock);
        #1;
    endtask

    task automatic run_cycle(string name);
        #4;
        end_cycle(name);
    endtask

    task automatic expect_fall_through(string name);
        logic  [FETCH_WIDTH-1:0] exp_valid;
        addr_t [FETCH_WIDTH-1:0] exp_pc;

        exp_valid = '1;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            exp_pc[i] = pc_start + 32'(4 * i) + 32'd4;
        end
        check_pred(name, exp_valid, '0, exp_pc, pred_valid, pred_taken, pred_pc);
    endtask

    task automatic drive_random_traffic();
        logic [31:0] draw;

        draw = random_bits(4);
        pc_start = pool_pc(draw[2:0]) - (draw[3] ? 32'd4 : 32'd0);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            draw = random_bits(6);
            resolve_valid[i] = draw[0] | draw[1];
            resolve_taken[i] = draw[2];
            resolve_pc[i]    = pool_pc(draw[5:3]);
            draw = random_bits(30);
            resolve_target[i] = {draw[29:0], 2'b00};
        end
    endtask

    // setup then access phase, resolve lanes idle
    task automatic apb_access(string name, logic write, csr_addr_t addr,
                              logic [31:0] wdata, logic [31:0] exp_data, logic exp_err);
        resolve_valid = '0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        #4;
        // setup phase gives no response yet
        if (pready !== 1'b0) begin
            stop_on_error($sformatf("pready was high in the setup phase of %s", name));
        end
        check_slverr(name, 1'b0, pslverr);
        end_cycle(name);
        penable = 1'b1;
        #4;
        if (pready !== 1'b1) begin
            stop_on_error($sformatf("pready was not high in the access phase of %s", name));
        end
        check_slverr(name, exp_err, pslverr);
        if (!write && !exp_err) begin
            check_csr_data(name, exp_data, prdata);
        end
        end_cycle(name);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        addr_t                   train_pc;
        addr_t                   train_target;
        logic  [FETCH_WIDTH-1:0] exp_valid;
        addr_t [FETCH_WIDTH-1:0] exp_pc;
        logic  [31:0]            draw;

        reset          = 1'b1;
        pc_start       = '0;
        resolve_valid  = '0;
        resolve_pc     = '0;
        resolve_taken  = '0;
        resolve_target = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        cycle_count    = 0;
        lfsr_state     = LFSR_SEED;
        model_reset();
        repeat (RESET_LEN) @(posedge clock);
        #1;
        reset = 1'b0;

        // empty tables predict fall through
        for (int k = 0; k < 4; k++) begin
            draw = random_bits(30);
            pc_start = {draw[29:0], 2'b00};
            #4;
            expect_fall_through("after_reset");
            end_cycle("after_reset");
        end
        apb_access("count_after_reset", 1'b0, CSR_TAKEN_COUNT, '0, 32'd0, 1'b0);

        // walk the history to all ones so the last pht entry trains
        train_pc     = 32'h0000_1040;
        train_target = 32'h0000_8000;
        pc_start     = train_pc;
        resolve_valid    = '0;
        resolve_valid[0] = 1'b1;
        resolve_pc[0]     = train_pc;
        resolve_taken[0]  = 1'b1;
        resolve_target[0] = train_target;
        repeat (HIST_BITS + 1) run_cycle("btb_pht_training");
        resolve_valid = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            exp_valid[i] = (i == 0);
            exp_pc[i]    = train_pc + 32'(4 * i) + 32'd4;
        end
        exp_pc[0] = train_target;
        #4;
        check_pred("trained_taken", exp_valid, FETCH_WIDTH'(1), exp_pc,
                   pred_valid, pred_taken, pred_pc);
        end_cycle("trained_taken");

        repeat (RANDOM_LEN) begin
            drive_random_traffic();
            run_cycle("random_traffic");
        end

        // static fallback while the tables keep training
        apb_access("mode_off", 1'b1, CSR_MODE, 32'd0, '0, 1'b0);
        repeat (20) begin
            drive_random_traffic();
            #4;
            expect_fall_through("static_mode");
            end_cycle("static_mode");
        end
        apb_access("mode_on", 1'b1, CSR_MODE, 32'd1, '0, 1'b0);
        repeat (20) begin
            drive_random_traffic();
            run_cycle("mode_restored");
        end
        apb_access("mode_readback", 1'b0, CSR_MODE, '0, {31'b0, model_mode}, 1'b0);

        apb_access("taken_count", 1'b0, CSR_TAKEN_COUNT, '0, model_count, 1'b0);

        // error responses leave state alone
        apb_access("count_write", 1'b1, CSR_TAKEN_COUNT, 32'hdead_beef, '0, 1'b1);
        apb_access("count_kept", 1'b0, CSR_TAKEN_COUNT, '0, model_count, 1'b0);
        apb_access("unmapped_write", 1'b1, 4'h8, 32'd0, '0, 1'b1);
        apb_access("unmapped_read", 1'b0, 4'h8, '0, '0, 1'b1);
        apb_access("mode_kept", 1'b0, CSR_MODE, '0, {31'b0, model_mode}, 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

/* src.f */
rtl/bp_pkg.sv
rtl/resolve_if.sv
rtl/branch_target_buffer.sv
rtl/local_history_predictor.sv
rtl/predictor_csr.sv
rtl/fetch_predictor.sv
test/fetch_predictor_chk.sv
test/fetch_predictor_tb.sv

/* Makefile */
# Verilator build and run for the fetch predictor testbench

VERILATOR ?= verilator
TOP       ?= fetch_predictor_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the simulator exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
